//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int xlen             = 32;
    localparam int num_phys_default = 64;

    typedef logic [4:0] arch_tag_t;
    typedef logic [5:0] phys_tag_t;
    typedef logic [3:0] rob_idx_t;

    // ========================================
    // Instruction encodings
    // ========================================
    localparam logic [5:0] op_reg  = 6'h00;
    localparam logic [5:0] op_addi = 6'h08;
    localparam logic [5:0] op_andi = 6'h0c;

    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_xor = 6'h26;
    localparam logic [5:0] fn_mul = 6'h18;

    typedef struct packed {
        logic [5:0] opcode;
        arch_tag_t  rd;
        arch_tag_t  rs1;
        arch_tag_t  rs2;
        logic [4:0] unused;
        logic [5:0] func;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]         opcode;
        arch_tag_t          rd;
        arch_tag_t          rs1;
        logic signed [15:0] imm;
    } i_fmt_t;

    // Same 32-bit word, register form or immediate form
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_mul
    } alu_op_e;

    // ========================================
    // Pipeline records
    // ========================================
    typedef struct packed {
        logic            valid;
        alu_op_e         op;
        arch_tag_t       rd;
        arch_tag_t       rs1;
        arch_tag_t       rs2;
        logic            uses_rs2;
        logic [xlen-1:0] imm;
        logic            is_mul;
    } decoded_t;

    typedef struct packed {
        logic            valid;
        alu_op_e         op;
        logic            is_mul;
        phys_tag_t       prd;
        phys_tag_t       prs1;
        phys_tag_t       prs2;
        logic            uses_rs2;
        logic [xlen-1:0] imm;
        rob_idx_t        rob;
    } renamed_t;

    // Rename result seen by the reorder buffer and register file
    typedef struct packed {
        logic      valid;
        arch_tag_t rd;
        phys_tag_t prd;
        phys_tag_t old_prd;
    } alloc_t;

    typedef struct packed {
        logic            valid;
        alu_op_e         op;
        logic            is_mul;
        phys_tag_t       prd;
        rob_idx_t        rob;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
    } exec_req_t;

    typedef struct packed {
        logic            valid;
        phys_tag_t       prd;
        rob_idx_t        rob;
        logic [xlen-1:0] value;
    } complete_t;

    typedef struct packed {
        logic            valid;
        arch_tag_t       rd;
        logic [xlen-1:0] value;
    } commit_t;

endpackage

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     instr_valid,
    input  instr_u   instr,
    input  logic     rename_go,
    output logic     ready,
    output decoded_t dec
);

    decoded_t nxt;
    logic     legal;

    // Register is free when empty or draining into rename
    assign ready = !dec.valid || rename_go;

    always_comb begin
        nxt   = '0;
        legal = 1'b1;
        case (instr.r_fmt.opcode)
            op_reg: begin
                nxt.rd       = instr.r_fmt.rd;
                nxt.rs1      = instr.r_fmt.rs1;
                nxt.rs2      = instr.r_fmt.rs2;
                nxt.uses_rs2 = 1'b1;
                case (instr.r_fmt.func)
                    fn_add:  nxt.op = alu_add;
                    fn_sub:  nxt.op = alu_sub;
                    fn_and:  nxt.op = alu_and;
                    fn_or:   nxt.op = alu_or;
                    fn_xor:  nxt.op = alu_xor;
                    fn_mul: begin
                        nxt.op     = alu_mul;
                        nxt.is_mul = 1'b1;
                    end
                    default: legal = 1'b0;
                endcase
            end
            op_addi, op_andi: begin
                nxt.rd  = instr.i_fmt.rd;
                nxt.rs1 = instr.i_fmt.rs1;
                nxt.op  = (instr.i_fmt.opcode == op_addi) ? alu_add : alu_and;
                // Sign-extended immediate
                nxt.imm = {{(xlen - 16){instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
            end
            default: legal = 1'b0;
        endcase
        // Unknown words are dropped here
        nxt.valid = instr_valid && legal;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else if (ready) begin
            dec <= nxt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rename_stage.sv
`timescale 1ns/100ps
`default_nettype none

module rename_stage import core_pkg::*; #(
    parameter int NUM_PHYS  = num_phys_default,
    parameter int ROB_DEPTH = 16
) (
    input  logic      clk,
    input  logic      rst,
    input  decoded_t  dec,
    input  logic      accept,
    input  logic      freed_valid,
    input  phys_tag_t freed_tag,
    input  logic      rob_full,
    input  rob_idx_t  rob_tail,
    output logic      rename_go,
    output renamed_t  ren,
    output alloc_t    alloc
);

    localparam int num_arch = 32;
    localparam int fl_depth = NUM_PHYS - num_arch;
    localparam int fl_bits  = $clog2(fl_depth);
    localparam int rob_bits = $clog2(ROB_DEPTH);

    phys_tag_t          map_q  [num_arch];
    phys_tag_t          free_q [fl_depth];
    logic [fl_bits-1:0] fl_head;
    logic [fl_bits-1:0] fl_tail;
    logic [fl_bits:0]   fl_count;

    logic      need_tag;
    logic      pop;
    phys_tag_t new_prd;
    renamed_t  ren_d;

    // ========================================
    // Lookup and allocation
    // ========================================
    always_comb begin
        // x0 keeps tag 0 and takes nothing from the free list
        need_tag  = dec.rd != '0;
        new_prd   = need_tag ? free_q[fl_head] : '0;
        rename_go = dec.valid && accept && !rob_full && (!need_tag || fl_count != '0);
        pop       = rename_go && need_tag;

        alloc.valid   = rename_go;
        alloc.rd      = dec.rd;
        alloc.prd     = new_prd;
        alloc.old_prd = map_q[dec.rd];

        ren_d.valid    = rename_go;
        ren_d.op       = dec.op;
        ren_d.is_mul   = dec.is_mul;
        ren_d.prd      = new_prd;
        ren_d.prs1     = map_q[dec.rs1];
        ren_d.prs2     = dec.uses_rs2 ? map_q[dec.rs2] : '0;
        ren_d.uses_rs2 = dec.uses_rs2;
        ren_d.imm      = dec.imm;
        // Index width follows the buffer depth
        ren_d.rob      = rob_idx_t'(rob_tail[rob_bits-1:0]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ren.valid <= 1'b0;
        end else if (accept) begin
            ren <= ren_d;
        end
    end

    // ========================================
    // Rename table and free list
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_arch; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
            for (int i = 0; i < fl_depth; i++) begin
                free_q[i] <= phys_tag_t'(num_arch + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= (fl_bits + 1)'(fl_depth);
        end else begin
            if (pop) begin
                map_q[dec.rd] <= new_prd;
                fl_head <= (fl_head == fl_bits'(fl_depth - 1)) ? '0 : fl_head + 1'b1;
            end
            if (freed_valid) begin
                free_q[fl_tail] <= freed_tag;
                fl_tail <= (fl_tail == fl_bits'(fl_depth - 1)) ? '0 : fl_tail + 1'b1;
            end
            fl_count <= fl_count + (fl_bits + 1)'(freed_valid) - (fl_bits + 1)'(pop);
        end
    end

endmodule

`default_nettype wire

//--- verilog/issue_stage.sv
`timescale 1ns/100ps
`default_nettype none

module issue_stage import core_pkg::*; #(
    parameter int NUM_PHYS = num_phys_default
) (
    input  logic                  clk,
    input  logic                  rst,
    input  renamed_t              ren,
    input  logic [1:0]            rd_ready,
    input  logic [1:0][xlen-1:0]  rd_data,
    output logic                  accept,
    output phys_tag_t [1:0]       rd_tag,
    output exec_req_t             exec_req
);

    localparam int tag_bits = $clog2(NUM_PHYS);

    renamed_t held;
    logic     fire;

    // Only the implemented tag range is looked up
    assign rd_tag[0] = phys_tag_t'(held.prs1[tag_bits-1:0]);
    assign rd_tag[1] = phys_tag_t'(held.prs2[tag_bits-1:0]);

    // In order: the held op blocks everything behind it
    assign fire   = held.valid && rd_ready[0] && (rd_ready[1] || !held.uses_rs2);
    assign accept = !held.valid || fire;

    always_comb begin
        exec_req.valid  = fire;
        exec_req.op     = held.op;
        exec_req.is_mul = held.is_mul;
        exec_req.prd    = held.prd;
        exec_req.rob    = held.rob;
        exec_req.a      = rd_data[0];
        exec_req.b      = held.uses_rs2 ? rd_data[1] : held.imm;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held.valid <= 1'b0;
        end else if (accept) begin
            held <= ren;
        end
    end

endmodule

`default_nettype wire

//--- verilog/phys_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module phys_regfile import core_pkg::*; #(
    parameter int NUM_PHYS = num_phys_default
) (
    input  logic                 clk,
    input  logic                 rst,
    input  alloc_t               alloc,
    input  complete_t            alu_done,
    input  complete_t            mul_done,
    input  phys_tag_t [1:0]      rd_tag,
    output logic [1:0]           rd_ready,
    output logic [1:0][xlen-1:0] rd_data
);

    logic [xlen-1:0] value_q [NUM_PHYS];
    logic            ready_q [NUM_PHYS];

    complete_t [1:0] wr;

    assign wr = {mul_done, alu_done};

    // Tag 0 is never written or cleared, so it stays zero and ready
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PHYS; i++) begin
                value_q[i] <= '0;
                ready_q[i] <= 1'b1;
            end
        end else begin
            if (alloc.valid && alloc.prd != '0) begin
                ready_q[alloc.prd] <= 1'b0;
            end
            for (int p = 0; p < 2; p++) begin
                if (wr[p].valid && wr[p].prd != '0) begin
                    value_q[wr[p].prd] <= wr[p].value;
                    ready_q[wr[p].prd] <= 1'b1;
                end
            end
        end
    end

    // Plain reads, no forwarding from the write ports
    always_comb begin
        for (int r = 0; r < 2; r++) begin
            rd_data[r]  = value_q[rd_tag[r]];
            rd_ready[r] = ready_q[rd_tag[r]];
        end
    end

endmodule

`default_nettype wire

//--- verilog/exec_units.sv
`timescale 1ns/100ps
`default_nettype none

module exec_units import core_pkg::*; #(
    parameter int MUL_LATENCY = 3
) (
    input  logic      clk,
    input  logic      rst,
    input  exec_req_t exec_req,
    output complete_t alu_done,
    output complete_t mul_done
);

    complete_t       mul_pipe [MUL_LATENCY];
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] product;

    // ========================================
    // Single-cycle ALU
    // ========================================
    always_comb begin
        case (exec_req.op)
            alu_add: alu_result = exec_req.a + exec_req.b;
            alu_sub: alu_result = exec_req.a - exec_req.b;
            alu_and: alu_result = exec_req.a & exec_req.b;
            alu_or:  alu_result = exec_req.a | exec_req.b;
            alu_xor: alu_result = exec_req.a ^ exec_req.b;
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_done.valid <= 1'b0;
        end else begin
            alu_done.valid <= exec_req.valid && !exec_req.is_mul;
            alu_done.prd   <= exec_req.prd;
            alu_done.rob   <= exec_req.rob;
            alu_done.value <= alu_result;
        end
    end

    // ========================================
    // Multiplier pipe
    // ========================================
    // Low word only
    assign product = exec_req.a * exec_req.b;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MUL_LATENCY; i++) begin
                mul_pipe[i].valid <= 1'b0;
            end
        end else begin
            mul_pipe[0].valid <= exec_req.valid && exec_req.is_mul;
            mul_pipe[0].prd   <= exec_req.prd;
            mul_pipe[0].rob   <= exec_req.rob;
            mul_pipe[0].value <= product;
            // One new product can enter every cycle
            for (int i = 1; i < MUL_LATENCY; i++) begin
                mul_pipe[i] <= mul_pipe[i-1];
            end
        end
    end

    assign mul_done = mul_pipe[MUL_LATENCY-1];

endmodule

`default_nettype wire

//--- verilog/reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer import core_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic      clk,
    input  logic      rst,
    input  alloc_t    alloc,
    input  complete_t alu_done,
    input  complete_t mul_done,
    output logic      rob_full,
    output rob_idx_t  rob_tail,
    output commit_t   commit,
    output logic      freed_valid,
    output phys_tag_t freed_tag
);

    localparam int cnt_bits = $clog2(ROB_DEPTH + 1);

    arch_tag_t       rd_q    [ROB_DEPTH];
    phys_tag_t       old_q   [ROB_DEPTH];
    logic            done_q  [ROB_DEPTH];
    logic [xlen-1:0] value_q [ROB_DEPTH];

    rob_idx_t            head;
    rob_idx_t            tail;
    logic [cnt_bits-1:0] count;
    logic                retire;

    assign rob_full = count == cnt_bits'(ROB_DEPTH);
    assign rob_tail = tail;

    // ========================================
    // Retire from the head in program order
    // ========================================
    assign retire = count != '0 && done_q[head];

    always_comb begin
        commit.valid = retire;
        commit.rd    = rd_q[head];
        // x0 results are discarded
        commit.value = (rd_q[head] == '0) ? '0 : value_q[head];
    end

    assign freed_valid = retire && rd_q[head] != '0 && old_q[head] != '0;
    assign freed_tag   = old_q[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc.valid) begin
                tail <= (tail == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (retire) begin
                head <= (head == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count <= count + cnt_bits'(alloc.valid) - cnt_bits'(retire);
        end
    end

    // Entry fill and completion marking
    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            rd_q[tail]   <= alloc.rd;
            old_q[tail]  <= alloc.old_prd;
            done_q[tail] <= 1'b0;
        end
        if (alu_done.valid) begin
            done_q[alu_done.rob]  <= 1'b1;
            value_q[alu_done.rob] <= alu_done.value;
        end
        if (mul_done.valid) begin
            done_q[mul_done.rob]  <= 1'b1;
            value_q[mul_done.rob] <= mul_done.value;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ooo_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_core_top import core_pkg::*; #(
    parameter int NUM_PHYS    = num_phys_default,
    parameter int ROB_DEPTH   = 16,
    parameter int MUL_LATENCY = 3
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    instr_valid,
    input  instr_u  instr,
    output logic    ready,
    output commit_t commit
);

    // ========================================
    // Stage records and handshakes
    // ========================================
    decoded_t             dec;
    renamed_t             ren;
    alloc_t               alloc;
    exec_req_t            exec_req;
    complete_t            alu_done;
    complete_t            mul_done;
    logic                 rename_go;
    logic                 accept;
    logic                 rob_full;
    rob_idx_t             rob_tail;
    logic                 freed_valid;
    phys_tag_t            freed_tag;
    phys_tag_t [1:0]      rd_tag;
    logic [1:0]           rd_ready;
    logic [1:0][xlen-1:0] rd_data;

    decode_stage u_decode (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
        .rename_go(rename_go), .ready(ready), .dec(dec)
    );

    rename_stage #(.NUM_PHYS(NUM_PHYS), .ROB_DEPTH(ROB_DEPTH)) u_rename (
        .clk(clk), .rst(rst), .dec(dec), .accept(accept),
        .freed_valid(freed_valid), .freed_tag(freed_tag),
        .rob_full(rob_full), .rob_tail(rob_tail),
        .rename_go(rename_go), .ren(ren), .alloc(alloc)
    );

    issue_stage #(.NUM_PHYS(NUM_PHYS)) u_issue (
        .clk(clk), .rst(rst), .ren(ren), .rd_ready(rd_ready), .rd_data(rd_data),
        .accept(accept), .rd_tag(rd_tag), .exec_req(exec_req)
    );

    phys_regfile #(.NUM_PHYS(NUM_PHYS)) u_prf (
        .clk(clk), .rst(rst), .alloc(alloc), .alu_done(alu_done), .mul_done(mul_done),
        .rd_tag(rd_tag), .rd_ready(rd_ready), .rd_data(rd_data)
    );

    exec_units #(.MUL_LATENCY(MUL_LATENCY)) u_exec (
        .clk(clk), .rst(rst), .exec_req(exec_req),
        .alu_done(alu_done), .mul_done(mul_done)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk(clk), .rst(rst), .alloc(alloc), .alu_done(alu_done), .mul_done(mul_done),
        .rob_full(rob_full), .rob_tail(rob_tail), .commit(commit),
        .freed_valid(freed_valid), .freed_tag(freed_tag)
    );

endmodule

`default_nettype wire

//--- tests/tb_ooo_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ooo_core import core_pkg::*; ();

    localparam int num_phys     = 64;
    localparam int rob_depth    = 16;
    localparam int mul_latency  = 3;
    localparam int num_random   = 80;
    localparam int period       = 100;
    localparam int drive_delay  = 10;
    localparam int reset_cycles = 8;
    localparam int drain_limit  = 2000;

    typedef struct packed {
        instr_u          word;
        logic            has_commit;
        arch_tag_t       rd;
        logic [xlen-1:0] value;
    } vector_t;

    typedef struct packed {
        arch_tag_t       rd;
        logic [xlen-1:0] value;
    } expect_t;

    logic    clk;
    logic    rst;
    logic    instr_valid;
    instr_u  instr;
    logic    ready;
    commit_t commit;

    vector_t         vectors [$];
    expect_t         exp_q [$];
    logic [xlen-1:0] arch_regs [32];
    int              rd_errors;
    int              value_errors;
    int              other_errors;
    int              commit_count;

    ooo_core_top #(
        .NUM_PHYS(num_phys), .ROB_DEPTH(rob_depth), .MUL_LATENCY(mul_latency)
    ) u_ooo_core_top (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
        .ready(ready), .commit(commit)
    );

    initial clk = 1'b0;
    always #(period / 2) clk = ~clk;

    // ========================================
    // Instruction encoding
    // ========================================
    function automatic instr_u enc_reg(arch_tag_t rd, arch_tag_t rs1, arch_tag_t rs2,
                                       logic [5:0] func);
        instr_u w;
        w.r_fmt.opcode = op_reg;
        w.r_fmt.rd     = rd;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.rs2    = rs2;
        w.r_fmt.unused = '0;
        w.r_fmt.func   = func;
        return w;
    endfunction

    function automatic instr_u enc_imm(logic [5:0] opcode, arch_tag_t rd, arch_tag_t rs1,
                                       logic [15:0] imm);
        instr_u w;
        w.i_fmt.opcode = opcode;
        w.i_fmt.rd     = rd;
        w.i_fmt.rs1    = rs1;
        w.i_fmt.imm    = imm;
        return w;
    endfunction

    function automatic instr_u random_instr();
        instr_u      w;
        logic [2:0]  pick;
        arch_tag_t   rd;
        arch_tag_t   rs1;
        arch_tag_t   rs2;
        logic [15:0] imm;
        pick = 3'($urandom_range(7, 0));
        // Nonzero destination so every word takes a tag
        rd   = 5'($urandom_range(31, 1));
        rs1  = 5'($urandom);
        rs2  = 5'($urandom);
        imm  = 16'($urandom);
        case (pick)
            3'd0: w = enc_reg(rd, rs1, rs2, fn_add);
            3'd1: w = enc_reg(rd, rs1, rs2, fn_sub);
            3'd2: w = enc_reg(rd, rs1, rs2, fn_and);
            3'd3: w = enc_reg(rd, rs1, rs2, fn_or);
            3'd4: w = enc_reg(rd, rs1, rs2, fn_xor);
            3'd5: w = enc_reg(rd, rs1, rs2, fn_mul);
            3'd6: w = enc_imm(op_addi, rd, rs1, imm);
            default: w = enc_imm(op_andi, rd, rs1, imm);
        endcase
        return w;
    endfunction

    // ========================================
    // Architectural reference model
    // ========================================
    task automatic predict(input instr_u w, output logic legal, output arch_tag_t rd,
                           output logic [xlen-1:0] value);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] imm;
        legal = 1'b1;
        rd    = w.r_fmt.rd;
        a     = arch_regs[w.r_fmt.rs1];
        b     = arch_regs[w.r_fmt.rs2];
        imm   = {{16{w.i_fmt.imm[15]}}, w.i_fmt.imm};
        value = '0;
        case (w.r_fmt.opcode)
            op_reg: begin
                case (w.r_fmt.func)
                    fn_add:  value = a + b;
                    fn_sub:  value = a - b;
                    fn_and:  value = a & b;
                    fn_or:   value = a | b;
                    fn_xor:  value = a ^ b;
                    fn_mul:  value = a * b;
                    default: legal = 1'b0;
                endcase
            end
            op_addi: value = a + imm;
            op_andi: value = a & imm;
            default: legal = 1'b0;
        endcase
        // x0 is hardwired to zero
        if (rd == '0) begin
            value = '0;
        end
        if (legal && rd != '0) begin
            arch_regs[rd] = value;
        end
    endtask

    task automatic add_vector(input instr_u word, input logic has_commit, input arch_tag_t rd,
                              input logic [xlen-1:0] value);
        vector_t v;
        v.word       = word;
        v.has_commit = has_commit;
        v.rd         = rd;
        v.value      = value;
        vectors.push_back(v);
    endtask

    // ========================================
    // Directed table
    // ========================================
    task automatic load_vectors();
        // First reads see zero
        add_vector(enc_imm(op_addi, 5'd1, 5'd5, 16'h0007), 1'b1, 5'd1, 32'h0000_0007);
        add_vector(enc_reg(5'd21, 5'd30, 5'd31, fn_add), 1'b1, 5'd21, 32'h0000_0000);
        add_vector(enc_imm(op_addi, 5'd2, 5'd0, 16'hfffd), 1'b1, 5'd2, 32'hffff_fffd);
        // Every register form ALU op
        add_vector(enc_reg(5'd3, 5'd1, 5'd2, fn_add), 1'b1, 5'd3, 32'h0000_0004);
        add_vector(enc_reg(5'd4, 5'd1, 5'd2, fn_sub), 1'b1, 5'd4, 32'h0000_000a);
        add_vector(enc_reg(5'd5, 5'd1, 5'd2, fn_and), 1'b1, 5'd5, 32'h0000_0005);
        add_vector(enc_reg(5'd6, 5'd1, 5'd2, fn_or), 1'b1, 5'd6, 32'hffff_ffff);
        add_vector(enc_reg(5'd7, 5'd1, 5'd2, fn_xor), 1'b1, 5'd7, 32'hffff_fffa);
        // Immediates of both signs
        add_vector(enc_imm(op_andi, 5'd8, 5'd2, 16'h00f0), 1'b1, 5'd8, 32'h0000_00f0);
        add_vector(enc_imm(op_andi, 5'd9, 5'd6, 16'hfff0), 1'b1, 5'd9, 32'hffff_fff0);
        add_vector(enc_imm(op_addi, 5'd10, 5'd1, 16'h7fff), 1'b1, 5'd10, 32'h0000_8006);
        add_vector(enc_imm(op_addi, 5'd22, 5'd1, 16'hfff6), 1'b1, 5'd22, 32'hffff_fffd);
        // Dependent chain through the multiplier
        add_vector(enc_reg(5'd11, 5'd1, 5'd4, fn_mul), 1'b1, 5'd11, 32'h0000_0046);
        add_vector(enc_imm(op_addi, 5'd11, 5'd11, 16'h0005), 1'b1, 5'd11, 32'h0000_004b);
        add_vector(enc_reg(5'd12, 5'd11, 5'd11, fn_mul), 1'b1, 5'd12, 32'h0000_15f9);
        add_vector(enc_reg(5'd13, 5'd12, 5'd11, fn_sub), 1'b1, 5'd13, 32'h0000_15ae);
        add_vector(enc_reg(5'd14, 5'd13, 5'd2, fn_mul), 1'b1, 5'd14, 32'hffff_bef6);
        // Slow multiply ahead of fast independent adds
        add_vector(enc_reg(5'd15, 5'd10, 5'd10, fn_mul), 1'b1, 5'd15, 32'h4006_0024);
        add_vector(enc_imm(op_addi, 5'd16, 5'd0, 16'h0001), 1'b1, 5'd16, 32'h0000_0001);
        add_vector(enc_imm(op_addi, 5'd17, 5'd0, 16'h0002), 1'b1, 5'd17, 32'h0000_0002);
        add_vector(enc_reg(5'd18, 5'd1, 5'd1, fn_add), 1'b1, 5'd18, 32'h0000_000e);
        // x0 writes and unknown words
        add_vector(enc_reg(5'd0, 5'd1, 5'd1, fn_add), 1'b1, 5'd0, 32'h0000_0000);
        add_vector(enc_imm(op_addi, 5'd0, 5'd0, 16'h0064), 1'b1, 5'd0, 32'h0000_0000);
        add_vector(enc_imm(op_addi, 5'd19, 5'd0, 16'h0009), 1'b1, 5'd19, 32'h0000_0009);
        add_vector(instr_u'(32'hfc00_0000), 1'b0, 5'd0, 32'h0000_0000);
        add_vector(enc_reg(5'd23, 5'd1, 5'd1, 6'h3f), 1'b0, 5'd0, 32'h0000_0000);
        add_vector(enc_reg(5'd20, 5'd0, 5'd19, fn_add), 1'b1, 5'd20, 32'h0000_0009);
        add_vector(enc_reg(5'd0, 5'd1, 5'd1, fn_mul), 1'b1, 5'd0, 32'h0000_0000);
        add_vector(enc_reg(5'd24, 5'd0, 5'd0, fn_or), 1'b1, 5'd24, 32'h0000_0000);
    endtask

    // Holds the word until the DUT takes it and returns just after the accepting edge
    task automatic send(input instr_u w);
        while (!ready) begin
            instr_valid = 1'b0;
            @(posedge clk);
            #(drive_delay);
        end
        instr       = w;
        instr_valid = 1'b1;
        @(posedge clk);
        #(drive_delay);
    endtask

    task automatic check_commit_rd(input arch_tag_t got, input arch_tag_t exp);
        if (got !== exp) begin
            rd_errors++;
            $display("[FAIL] commit.rd got 0x%h expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_commit_value(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] commit.value got 0x%h expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    // ========================================
    // Commit monitor
    // ========================================
    always @(negedge clk) begin : commit_monitor
        expect_t e;
        if (!rst && commit.valid) begin
            commit_count++;
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Commit of rd %0d at %0t arrived with no instruction waiting for it",
                         commit.rd, $time);
            end else begin
                e = exp_q.pop_front();
                check_commit_rd(commit.rd, e.rd);
                check_commit_value(commit.value, e.value);
            end
        end
    end

    initial begin : watchdog
        longint limit_ns;
        #1;
        limit_ns = longint'(vectors.size() + num_random) * (mul_latency + rob_depth + 10)
                   * period;
        #(limit_ns);
        $display("Watchdog expired after %0d ns with %0d commits still outstanding",
                 limit_ns, exp_q.size());
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main_sequence
        instr_u          w;
        logic            legal;
        arch_tag_t       rd;
        logic [xlen-1:0] value;
        expect_t         e;
        int              drain;
        void'($urandom(32'hc78e));
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        rd_errors    = 0;
        value_errors = 0;
        other_errors = 0;
        commit_count = 0;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = '0;
        end
        load_vectors();

        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        rst = 1'b0;

        // Idle pipeline after reset
        if (ready !== 1'b1) begin
            other_errors++;
            $display("ready is not high after reset");
        end
        repeat (10) @(posedge clk);
        #(drive_delay);
        if (commit_count != 0) begin
            other_errors++;
            $display("Commits appeared with no instruction sent");
        end

        foreach (vectors[i]) begin
            predict(vectors[i].word, legal, rd, value);
            if (vectors[i].has_commit) begin
                e.rd    = vectors[i].rd;
                e.value = vectors[i].value;
                exp_q.push_back(e);
            end
            send(vectors[i].word);
        end

        // Random burst long enough to recycle the whole free list
        for (int n = 0; n < num_random; n++) begin
            w = random_instr();
            predict(w, legal, rd, value);
            if (legal) begin
                e.rd    = rd;
                e.value = value;
                exp_q.push_back(e);
            end
            send(w);
        end
        instr_valid = 1'b0;

        drain = 0;
        while (exp_q.size() != 0 && drain < drain_limit) begin
            @(posedge clk);
            drain++;
        end
        // Extra cycles to catch stray commits
        repeat (2 * (mul_latency + rob_depth)) @(posedge clk);
        if (exp_q.size() != 0) begin
            other_errors += exp_q.size();
            $display("%0d expected commits never arrived", exp_q.size());
        end

        $display("Commits %0d, rd errors %0d, value errors %0d, other errors %0d",
                 commit_count, rd_errors, value_errors, other_errors);
        if (rd_errors + value_errors + other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
verilog/core_pkg.sv
verilog/decode_stage.sv
verilog/rename_stage.sv
verilog/issue_stage.sv
verilog/phys_regfile.sv
verilog/exec_units.sv
verilog/reorder_buffer.sv
verilog/ooo_core_top.sv
tests/tb_ooo_core.sv

//--- Makefile
SIM        = verilator
SIM_FLAGS  = --binary --timing -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_ooo_core
RTL_TOP    = ooo_core_top
FLIST      = flist.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Simulation finished: FAIL
PASS_MSG   = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Test failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
